// File: src/bus_pkg.sv
// Bus fabric definitions
// widths, master request structs, slave indices and the I/O page map
// addresses are byte addresses with the console-mode bit on top

package bus_pkg;

	//**************************************************************************
	// widths
	//**************************************************************************
	typedef logic [16:0] addr_t;    // byte address, bit 16 = console mode
	typedef logic [15:0] dma_adr_t; // DMA masters see only 64 KB
	typedef logic [15:0] data_t;    // bus data word
	typedef logic [1:0]  sel_t;     // byte lanes, [1] high byte

	// request as driven by a bus master
	typedef struct packed {
		addr_t adr;
		data_t dat;
		logic  cyc;  // bus cycle open
		logic  we;   // 1 = write
		sel_t  sel;
		logic  stb;
	} wb_req_t;

	// request as driven by a DMA controller
	typedef struct packed {
		logic     req;  // held for as long as the bus is needed
		dma_adr_t adr;
		data_t    dat;
		logic     we;   // 1 = disk to memory
		logic     stb;
	} dma_req_t;

	//**************************************************************************
	// slaves on the bus
	//**************************************************************************
	localparam int SLAVES = 10;

	typedef enum logic [3:0] {
		SL_ROM,   // monitor ROM
		SL_DRAM,  // main memory
		SL_UART1, // console serial port
		SL_UART2, // second serial port
		SL_LPT,   // printer
		SL_RK,
		SL_DW,
		SL_RX,
		SL_MY,
		SL_KGD    // graphics adapter
	} slave_e;

	typedef logic [SLAVES-1:0]  slave_vec_t;  // one bit per slave
	typedef data_t [SLAVES-1:0] slave_dat_t;  // read data, indexed by slave_e

	typedef enum logic [1:0] {BUS_CPU, BUS_RK, BUS_MY} bus_owner_e;

	// I/O page, base address and lowest compared bit
	localparam addr_t UART1_BASE = 17'o177560;
	localparam int    UART1_LSB  = 3;
	localparam addr_t UART2_BASE = 17'o176500;
	localparam int    UART2_LSB  = 3;
	localparam addr_t LPT_BASE   = 17'o177514;
	localparam int    LPT_LSB    = 2;
	localparam addr_t RK_BASE    = 17'o177400;
	localparam int    RK_LSB     = 4;
	localparam addr_t DW_BASE    = 17'o174000;
	localparam int    DW_LSB     = 5;
	localparam addr_t RX_BASE    = 17'o177170;
	localparam int    RX_LSB     = 2;
	localparam addr_t MY_BASE    = 17'o172140;
	localparam int    MY_LSB     = 2;
	localparam addr_t KGD_BASE   = 17'o176640;
	localparam int    KGD_LSB    = 3;

	localparam logic [3:0] ROM_TAG = 4'b1110; // shadow ROM, bits 16..13

endpackage

// File: src/board_pkg.sv
// Board level definitions
// SD-card sharing between the disk controllers, console speed table

package board_pkg;

	//**************************************************************************
	// SD card
	//**************************************************************************
	localparam int SD_DEVICES = 4;

	// bit positions of the disk controllers in sd_vec_t
	localparam int SD_IDX_RK = 0;
	localparam int SD_IDX_DW = 1;
	localparam int SD_IDX_DX = 2;
	localparam int SD_IDX_MY = 3;

	typedef logic [SD_DEVICES-1:0] sd_vec_t;

	typedef struct packed {
		logic mosi;
		logic cs;
	} sd_link_t;

	typedef sd_link_t [SD_DEVICES-1:0] sd_link_vec_t;

	typedef enum logic [2:0] {SD_IDLE, SD_RK, SD_DW, SD_DX, SD_MY} sd_owner_e;

	//**************************************************************************
	// serial ports
	//**************************************************************************
	typedef logic [2:0]  speed_idx_t; // terminal speed index
	typedef logic [15:0] baud_div_t;

	// 1200 .. 115200 baud off the 921600 Hz reference
	localparam baud_div_t TERM_DIVISORS [0:7] = '{
		16'd767, 16'd383, 16'd191, 16'd95,
		16'd47,  16'd23,  16'd15,  16'd7
	};

	localparam int REF_CLK_HZ = 921600;
	localparam int UART2_BAUD = 38400;
	localparam baud_div_t UART2_DIV = baud_div_t'(REF_CLK_HZ / UART2_BAUD - 1);

endpackage

// File: src/bus_master_switch.sv
// Bus master switch
// hands the bus to the CPU or one of the two DMA masters (RK11 before MY)
// ownership moves only between bus cycles

module bus_master_switch (
	input  logic              wb_clk,
	input  logic              arst_n_i,
	input  bus_pkg::wb_req_t  cpu_req_i,
	input  bus_pkg::dma_req_t rk_dma_i,
	input  bus_pkg::dma_req_t my_dma_i,
	input  logic              bus_ack_i,
	output bus_pkg::wb_req_t  bus_req_o,
	output logic              cpu_ack_o,
	output logic              rk_ack_o,
	output logic              my_ack_o,
	output logic              rk_gnt_o,
	output logic              my_gnt_o
);
	import bus_pkg::*;

	bus_owner_e owner_q;  // current master
	bus_owner_e owner_d;
	wb_req_t    rk_req;   // DMA requests in bus form
	wb_req_t    my_req;

	// DMA side has no byte lanes and no console bit
	function automatic wb_req_t dma_to_wb(input dma_req_t d);
		wb_req_t w;
		w.adr = {1'b0, d.adr};
		w.dat = d.dat;
		w.cyc = d.req;  // req doubles as cycle strobe
		w.we  = d.we;
		w.sel = 2'b11;  // always whole words
		w.stb = d.stb;
		return w;
	endfunction

	assign rk_req = dma_to_wb(rk_dma_i);
	assign my_req = dma_to_wb(my_dma_i);

	//**************************************************************************
	// arbitration
	//**************************************************************************
	always_comb begin
		owner_d = owner_q;
		if (!bus_req_o.cyc) begin  // idle bus, free to switch
			if (rk_dma_i.req)
				owner_d = BUS_RK;
			else if (my_dma_i.req)
				owner_d = BUS_MY;
			else
				owner_d = BUS_CPU;   // no DMA pending, back to the processor
		end
	end

	always_ff @(posedge wb_clk or negedge arst_n_i) begin
		if (!arst_n_i)
			owner_q <= BUS_CPU;
		else
			owner_q <= owner_d;
	end

	//**************************************************************************
	// master multiplexer
	//**************************************************************************
	always_comb begin
		case (owner_q)
			BUS_RK:  bus_req_o = rk_req;
			BUS_MY:  bus_req_o = my_req;
			default: bus_req_o = cpu_req_i;
		endcase
	end

	// ack back to the owner only, others keep waiting
	assign cpu_ack_o = bus_ack_i & (owner_q == BUS_CPU);
	assign rk_ack_o  = bus_ack_i & (owner_q == BUS_RK);
	assign my_ack_o  = bus_ack_i & (owner_q == BUS_MY);

	assign rk_gnt_o = (owner_q == BUS_RK);
	assign my_gnt_o = (owner_q == BUS_MY);

endmodule

// File: src/io_page_decoder.sv
// I/O page decoder
// turns the bus address into slave strobes, merges read data and acks

module io_page_decoder (
	input  bus_pkg::wb_req_t   bus_req_i,
	input  bus_pkg::slave_vec_t slave_ack_i,
	input  bus_pkg::slave_dat_t slave_dat_i,
	output bus_pkg::slave_vec_t slave_stb_o,
	output logic                bus_ack_o,
	output bus_pkg::data_t      bus_dat_o
);
	import bus_pkg::*;

	addr_t      adr;
	logic       access;  // strobe inside an open cycle
	slave_vec_t hit;     // address match, before qualifying

	// compare address bits 16..lsb against a base
	function automatic logic page_hit(input addr_t a, input addr_t base,
			input int unsigned lsb);
		return (a >> lsb) == (base >> lsb);
	endfunction

	assign adr    = bus_req_i.adr;
	assign access = bus_req_i.stb & bus_req_i.cyc;

	//**************************************************************************
	// address map
	//**************************************************************************
	always_comb begin
		hit = '0;
		hit[SL_UART1] = page_hit(adr, UART1_BASE, UART1_LSB); // 177560-177566
		hit[SL_UART2] = page_hit(adr, UART2_BASE, UART2_LSB); // 176500-176506
		hit[SL_LPT]   = page_hit(adr, LPT_BASE, LPT_LSB);     // 177514-177516
		hit[SL_RK]    = page_hit(adr, RK_BASE, RK_LSB);       // 177400-177416
		hit[SL_DW]    = page_hit(adr, DW_BASE, DW_LSB);       // 174000-174036
		hit[SL_RX]    = page_hit(adr, RX_BASE, RX_LSB);       // 177170-177172
		hit[SL_MY]    = page_hit(adr, MY_BASE, MY_LSB);       // 172140-172142
		hit[SL_KGD]   = page_hit(adr, KGD_BASE, KGD_LSB);     // 176640-176646

		// monitor ROM in the shadow area
		hit[SL_ROM] = (adr[16:13] == ROM_TAG);

		// user mode sees memory below 160000
		// console mode swaps in the top 8 KB and hides the rest
		hit[SL_DRAM] = (adr[15:13] != 3'b111) ^ adr[16];
	end

	assign slave_stb_o = access ? hit : '0;

	//**************************************************************************
	// return path
	//**************************************************************************
	assign bus_ack_o = |slave_ack_i;  // whoever answers

	// OR of the selected words, zero with nothing selected
	always_comb begin
		bus_dat_o = '0;
		for (int i = 0; i < SLAVES; i++) begin
			if (slave_stb_o[i])
				bus_dat_o = bus_dat_o | slave_dat_i[i];
		end
	end

endmodule

// File: src/sdcard_arbiter.sv
// SD card arbiter
// one of four disk controllers owns the card until it lets go
// fixed priority RK, DW, DX, MY when the card is free

module sdcard_arbiter (
	input  logic                    wb_clk,
	input  logic                    arst_n_i,
	input  board_pkg::sd_vec_t      sd_req_i,
	input  board_pkg::sd_link_vec_t sd_link_i,
	output board_pkg::sd_vec_t      sd_gnt_o,
	output logic                    sdcard_mosi_o,
	output logic                    sdcard_cs_o
);
	import board_pkg::*;

	sd_owner_e owner_q;
	sd_owner_e owner_d;
	sd_link_t  card;     // lines of the current owner

	//**************************************************************************
	// ownership FSM
	//**************************************************************************
	always_comb begin
		owner_d = owner_q;
		case (owner_q)
			SD_IDLE: begin  // look for a requester
				if (sd_req_i[SD_IDX_RK])
					owner_d = SD_RK;
				else if (sd_req_i[SD_IDX_DW])
					owner_d = SD_DW;
				else if (sd_req_i[SD_IDX_DX])
					owner_d = SD_DX;
				else if (sd_req_i[SD_IDX_MY])
					owner_d = SD_MY;
			end
			// hold until the owner drops its request
			SD_RK: if (!sd_req_i[SD_IDX_RK]) owner_d = SD_IDLE;
			SD_DW: if (!sd_req_i[SD_IDX_DW]) owner_d = SD_IDLE;
			SD_DX: if (!sd_req_i[SD_IDX_DX]) owner_d = SD_IDLE;
			SD_MY: if (!sd_req_i[SD_IDX_MY]) owner_d = SD_IDLE;
			default: owner_d = SD_IDLE;
		endcase
	end

	always_ff @(posedge wb_clk or negedge arst_n_i) begin
		if (!arst_n_i)
			owner_q <= SD_IDLE;
		else
			owner_q <= owner_d;
	end

	always_comb begin
		sd_gnt_o = '0;
		sd_gnt_o[SD_IDX_RK] = (owner_q == SD_RK);
		sd_gnt_o[SD_IDX_DW] = (owner_q == SD_DW);
		sd_gnt_o[SD_IDX_DX] = (owner_q == SD_DX);
		sd_gnt_o[SD_IDX_MY] = (owner_q == SD_MY);
	end

	// card lines, RK by default
	always_comb begin
		case (owner_q)
			SD_DW:   card = sd_link_i[SD_IDX_DW];
			SD_DX:   card = sd_link_i[SD_IDX_DX];
			SD_MY:   card = sd_link_i[SD_IDX_MY];
			default: card = sd_link_i[SD_IDX_RK];
		endcase
	end

	assign sdcard_mosi_o = card.mosi;
	assign sdcard_cs_o   = card.cs;

endmodule

// File: src/console_router.sv
// Console router
// swaps the two UARTs between hardware terminal and external port
// the terminal side runs at the terminal's own speed

module console_router (
	input  logic                  console_sel_i,  // 0 = UART1 on terminal
	input  board_pkg::speed_idx_t term_speed_i,
	input  logic                  uart1_txd_i,
	input  logic                  uart2_txd_i,
	input  logic                  terminal_tx_i,
	input  logic                  irps_rxd_i,
	output logic                  uart1_rxd_o,
	output logic                  uart2_rxd_o,
	output logic                  terminal_rx_o,
	output logic                  irps_txd_o,
	output board_pkg::baud_div_t  uart1_bdiv_o,
	output board_pkg::baud_div_t  uart2_bdiv_o
);
	import board_pkg::*;

	baud_div_t term_div;  // divisor matching the terminal

	assign term_div = TERM_DIVISORS[term_speed_i];

	//**************************************************************************
	// serial lines
	//**************************************************************************
	assign terminal_rx_o = console_sel_i ? uart2_txd_i : uart1_txd_i;
	assign irps_txd_o    = console_sel_i ? uart1_txd_i : uart2_txd_i;
	assign uart1_rxd_o   = console_sel_i ? irps_rxd_i : terminal_tx_i;
	assign uart2_rxd_o   = console_sel_i ? terminal_tx_i : irps_rxd_i;

	// divisors follow the lines
	assign uart1_bdiv_o = console_sel_i ? UART2_DIV : term_div;
	assign uart2_bdiv_o = console_sel_i ? term_div : UART2_DIV;

endmodule

// File: src/board_fabric.sv
// Board bus fabric
// master switch, I/O page decode, SD-card sharing and console routing

module board_fabric (
	input  logic                    wb_clk,
	input  logic                    arst_n_i,
	// masters
	input  bus_pkg::wb_req_t        cpu_req_i,
	input  bus_pkg::dma_req_t       rk_dma_i,
	input  bus_pkg::dma_req_t       my_dma_i,
	output logic                    cpu_ack_o,
	output logic                    rk_ack_o,
	output logic                    my_ack_o,
	output logic                    rk_gnt_o,
	output logic                    my_gnt_o,
	output bus_pkg::wb_req_t        bus_req_o,
	output bus_pkg::data_t          bus_dat_o,  // read data to all masters
	// slaves
	input  bus_pkg::slave_vec_t     slave_ack_i,
	input  bus_pkg::slave_dat_t     slave_dat_i,
	output bus_pkg::slave_vec_t     slave_stb_o,
	// SD card
	input  board_pkg::sd_vec_t      sd_req_i,
	input  board_pkg::sd_link_vec_t sd_link_i,
	output board_pkg::sd_vec_t      sd_gnt_o,
	output logic                    sdcard_mosi_o,
	output logic                    sdcard_cs_o,
	// console
	input  logic                    console_sel_i,
	input  board_pkg::speed_idx_t   term_speed_i,
	input  logic                    uart1_txd_i,
	input  logic                    uart2_txd_i,
	input  logic                    terminal_tx_i,
	input  logic                    irps_rxd_i,
	output logic                    uart1_rxd_o,
	output logic                    uart2_rxd_o,
	output logic                    terminal_rx_o,
	output logic                    irps_txd_o,
	output board_pkg::baud_div_t    uart1_bdiv_o,
	output board_pkg::baud_div_t    uart2_bdiv_o
);

	logic bus_ack;  // merged slave ack

	//**************************************************************************
	// bus
	//**************************************************************************
	bus_master_switch u_switch (
		.wb_clk    (wb_clk),
		.arst_n_i  (arst_n_i),
		.cpu_req_i (cpu_req_i),
		.rk_dma_i  (rk_dma_i),
		.my_dma_i  (my_dma_i),
		.bus_ack_i (bus_ack),
		.bus_req_o (bus_req_o),
		.cpu_ack_o (cpu_ack_o),
		.rk_ack_o  (rk_ack_o),
		.my_ack_o  (my_ack_o),
		.rk_gnt_o  (rk_gnt_o),
		.my_gnt_o  (my_gnt_o)
	);

	io_page_decoder u_decoder (
		.bus_req_i   (bus_req_o),
		.slave_ack_i (slave_ack_i),
		.slave_dat_i (slave_dat_i),
		.slave_stb_o (slave_stb_o),
		.bus_ack_o   (bus_ack),
		.bus_dat_o   (bus_dat_o)
	);

	//**************************************************************************
	// peripherals side
	//**************************************************************************
	sdcard_arbiter u_sd_arb (
		.wb_clk        (wb_clk),
		.arst_n_i      (arst_n_i),
		.sd_req_i      (sd_req_i),
		.sd_link_i     (sd_link_i),
		.sd_gnt_o      (sd_gnt_o),
		.sdcard_mosi_o (sdcard_mosi_o),
		.sdcard_cs_o   (sdcard_cs_o)
	);

	console_router u_console (
		.console_sel_i (console_sel_i),
		.term_speed_i  (term_speed_i),
		.uart1_txd_i   (uart1_txd_i),
		.uart2_txd_i   (uart2_txd_i),
		.terminal_tx_i (terminal_tx_i),
		.irps_rxd_i    (irps_rxd_i),
		.uart1_rxd_o   (uart1_rxd_o),
		.uart2_rxd_o   (uart2_rxd_o),
		.terminal_rx_o (terminal_rx_o),
		.irps_txd_o    (irps_txd_o),
		.uart1_bdiv_o  (uart1_bdiv_o),
		.uart2_bdiv_o  (uart2_bdiv_o)
	);

endmodule

// File: verification/tb_board_fabric.sv
// Board fabric testbench
// replays a stimulus trace against the fabric and compares every output
// slave read data is random, the trace names the expected strobes

module tb_board_fabric;
	timeunit 1ns;
	timeprecision 100ps;

	import bus_pkg::*;
	import board_pkg::*;

	localparam string TRACE_FILE      = "verification/fabric_trace.txt";
	localparam int    RESET_CYCLES    = 5;
	localparam int    CYCLES_PER_LINE = 20;   // timeout budget per trace line

	logic wb_clk = 1'b0;
	logic arst_n_i;
	wb_req_t cpu_req_i, bus_req_o;
	dma_req_t rk_dma_i, my_dma_i;
	logic cpu_ack_o, rk_ack_o, my_ack_o, rk_gnt_o, my_gnt_o;
	data_t bus_dat_o;
	slave_vec_t slave_ack_i, slave_stb_o;
	slave_dat_t slave_dat_i;
	sd_vec_t sd_req_i, sd_gnt_o;
	sd_link_vec_t sd_link_i;
	logic sdcard_mosi_o, sdcard_cs_o;
	logic console_sel_i;
	speed_idx_t term_speed_i;
	logic uart1_txd_i, uart2_txd_i, terminal_tx_i, irps_rxd_i;
	logic uart1_rxd_o, uart2_rxd_o, terminal_rx_o, irps_txd_o;
	baud_div_t uart1_bdiv_o, uart2_bdiv_o;

	data_t       rnd_word [SLAVES];  // word behind each slave
	logic [31:0] fld [0:5];          // fields of the current trace line
	logic [7:0]  op;
	int          cycles = 0;
	int          cycle_limit;
	int          steps = 0;

	board_fabric dut0 (.*);

	always #2 wb_clk = ~wb_clk;  // 4 ns period

	always @(posedge wb_clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit)
			stop_with_failure($sformatf("timeout, trace not done after %0d cycles", cycles));
	end

	//**************************************************************************
	// failure and compare tasks
	//**************************************************************************
	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "run stopped at first failure");
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
			stop_with_failure($sformatf("mismatch at %0d ns: %s is %b, expected %b",
				$time, what, got, exp));
	endtask

	task automatic check_slave_vec(input slave_vec_t got, input slave_vec_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("mismatch at %0d ns: slave strobes %h, expected %h",
				$time, got, exp));
	endtask

	task automatic check_data(input data_t got, input data_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("mismatch at %0d ns: read data %h, expected %h",
				$time, got, exp));
	endtask

	task automatic check_bus_req(input wb_req_t got, input wb_req_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("mismatch at %0d ns: bus request %h, expected %h",
				$time, got, exp));
	endtask

	// owner as seen from the two grant lines
	task automatic check_owner(input bus_owner_e exp);
		bus_owner_e got;
		if (rk_gnt_o && my_gnt_o) begin
			stop_with_failure("both DMA grants are high at the same time");
		end else begin
			if (rk_gnt_o)
				got = BUS_RK;
			else if (my_gnt_o)
				got = BUS_MY;
			else
				got = BUS_CPU;
			if (got != exp)
				stop_with_failure($sformatf("mismatch at %0d ns: bus owner %s, expected %s",
					$time, got.name(), exp.name()));
		end
	endtask

	task automatic check_sd(input sd_vec_t got, input sd_vec_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("mismatch at %0d ns: SD grants %h, expected %h",
				$time, got, exp));
	endtask

	task automatic check_baud(input baud_div_t got, input baud_div_t exp, input string what);
		if (got !== exp)
			stop_with_failure($sformatf("mismatch at %0d ns: %s divisor %0d, expected %0d",
				$time, what, got, exp));
	endtask

	// exp bits are {uart1_rxd, uart2_rxd, terminal_rx, irps_txd}
	task automatic compare_serial_lines(input logic [3:0] exp);
		check_bit(uart1_rxd_o, exp[3], "uart1 rxd");
		check_bit(uart2_rxd_o, exp[2], "uart2 rxd");
		check_bit(terminal_rx_o, exp[1], "terminal rx");
		check_bit(irps_txd_o, exp[0], "irps txd");
	endtask

	// word of the one strobed slave, zero with none strobed
	function automatic data_t expected_read_data(input slave_vec_t stb);
		data_t d;
		d = '0;
		for (int i = 0; i < SLAVES; i++)
			if (stb == (slave_vec_t'(1) << i))
				d = rnd_word[i];
		return d;
	endfunction

	// request the owner should put on the bus
	// DMA side zero-extended, cyc from req, both byte lanes
	function automatic wb_req_t expected_bus_req(input bus_owner_e owner);
		wb_req_t  w;
		dma_req_t d;
		w = cpu_req_i;
		if (owner != BUS_CPU) begin
			d = (owner == BUS_RK) ? rk_dma_i : my_dma_i;
			w.adr = {1'b0, d.adr};
			w.dat = d.dat;
			w.cyc = d.req;
			w.we  = d.we;
			w.sel = 2'b11;
			w.stb = d.stb;
		end
		return w;
	endfunction

	//**************************************************************************
	// trace steps, called right after a rising edge
	//**************************************************************************
	task automatic drive_address;
		cpu_req_i.adr <= fld[0][16:0];
		cpu_req_i.cyc <= fld[1][0];
		cpu_req_i.stb <= fld[2][0];
		slave_ack_i   <= fld[3][9:0];
		@(negedge wb_clk);  // decode is combinational
		check_bus_req(bus_req_o, expected_bus_req(BUS_CPU));
		check_slave_vec(slave_stb_o, fld[4][9:0]);
		check_data(bus_dat_o, expected_read_data(fld[4][9:0]));
		check_bit(cpu_ack_o, fld[5][0], "cpu ack");
	endtask

	task automatic arbitrate_dma;
		slave_vec_t ack;
		ack = '0;
		ack[SL_DRAM] = fld[3][0];  // any slave will do for the ack path
		cpu_req_i.cyc <= fld[0][0];
		cpu_req_i.stb <= fld[0][0];
		rk_dma_i.req  <= fld[1][0];
		rk_dma_i.stb  <= fld[1][0];
		my_dma_i.req  <= fld[2][0];
		my_dma_i.stb  <= fld[2][0];
		slave_ack_i   <= ack;
		@(negedge wb_clk);
		check_owner(bus_owner_e'(fld[4][1:0]));
		check_bus_req(bus_req_o, expected_bus_req(bus_owner_e'(fld[4][1:0])));
		check_bit(cpu_ack_o, fld[5][0], "cpu ack");
		check_bit(rk_ack_o, fld[5][1], "rk ack");
		check_bit(my_ack_o, fld[5][2], "my ack");
	endtask

	task automatic share_sdcard;
		sd_req_i  <= fld[0][3:0];
		sd_link_i <= fld[1][7:0];
		@(negedge wb_clk);
		check_sd(sd_gnt_o, fld[2][3:0]);
		check_bit(sdcard_mosi_o, fld[3][0], "card mosi");
		check_bit(sdcard_cs_o, fld[4][0], "card cs");
	endtask

	// same line checked in both switch positions, divisors swap with lines
	task automatic route_console;
		term_speed_i <= fld[0][2:0];
		{uart1_txd_i, uart2_txd_i, terminal_tx_i, irps_rxd_i} <= fld[1][3:0];
		console_sel_i <= 1'b0;
		@(negedge wb_clk);
		compare_serial_lines(fld[2][3:0]);
		check_baud(uart1_bdiv_o, fld[4][15:0], "uart1");
		check_baud(uart2_bdiv_o, fld[5][15:0], "uart2");
		@(posedge wb_clk);
		console_sel_i <= 1'b1;
		@(negedge wb_clk);
		compare_serial_lines(fld[3][3:0]);
		check_baud(uart1_bdiv_o, fld[5][15:0], "uart1");
		check_baud(uart2_bdiv_o, fld[4][15:0], "uart2");
	endtask

	//**************************************************************************
	// main sequence
	//**************************************************************************
	initial begin
		int fd;
		int n;
		int trace_lines;
		logic [31:0] rnd;
		logic [8*160-1:0] line_buf;
		arst_n_i = 1'b0;
		cpu_req_i = '0;
		cpu_req_i.sel = 2'b01;  // low byte only, unlike the DMA side
		rk_dma_i = '0;
		rk_dma_i.adr = 16'o177404;  // distinct words per master
		rk_dma_i.dat = 16'h3c5a;
		rk_dma_i.we = 1'b1;
		my_dma_i = '0;
		my_dma_i.adr = 16'o001000;
		my_dma_i.dat = 16'hc3a5;
		slave_ack_i = '0;
		sd_req_i = '0;
		sd_link_i = '0;
		console_sel_i = 1'b0;
		term_speed_i = '0;
		{uart1_txd_i, uart2_txd_i, terminal_tx_i, irps_rxd_i} = 4'hf;  // idle lines
		rnd = $urandom(55351);
		for (int i = 0; i < SLAVES; i++) begin
			rnd = $urandom();
			rnd_word[i] = rnd[15:0];
			slave_dat_i[i] = rnd_word[i];
		end
		// size the timeout from the trace length
		trace_lines = 0;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0)
			stop_with_failure("cannot open the trace file");
		while (!$feof(fd)) begin
			n = $fgets(line_buf, fd);
			if (n > 0)
				trace_lines++;
		end
		$fclose(fd);
		cycle_limit = CYCLES_PER_LINE * trace_lines + RESET_CYCLES;
		repeat (RESET_CYCLES) @(posedge wb_clk);
		arst_n_i <= 1'b1;
		fd = $fopen(TRACE_FILE, "r");
		n = $fscanf(fd, "%s", op);
		while (n == 1) begin
			if (op == "#") begin
				n = $fgets(line_buf, fd);  // skip comment
			end else begin
				n = $fscanf(fd, "%h %h %h %h %h %h",
					fld[0], fld[1], fld[2], fld[3], fld[4], fld[5]);
				if (n != 6)
					stop_with_failure("trace line with missing fields");
				@(posedge wb_clk);
				case (op)
					"A": drive_address();
					"D": arbitrate_dma();
					"S": share_sdcard();
					"C": route_console();
					default: stop_with_failure("unknown opcode in the trace");
				endcase
				steps++;
			end
			n = $fscanf(fd, "%s", op);
		end
		$fclose(fd);
		if (steps == 0) begin
			stop_with_failure("the trace held no test steps");
		end else begin
			$display("No errors");
			$finish;
		end
	end

endmodule

// File: verification/fabric_trace.txt
# op f1 f2 f3 f4 f5 f6 in hex, one clock per line, C lines take two
# registered outputs on a line show the state left by the lines before it
# A adr cyc stb slave_ack exp_strobes exp_cpu_ack
A 0FF70 1 1 004 004 1
A 0FD42 1 1 008 008 1
A 0FF4C 1 1 000 010 0
A 0FF04 1 1 020 020 1
A 0F810 1 1 040 040 1
A 0FE78 1 1 080 080 1
A 0F462 1 1 100 100 1
A 0FDA4 1 1 200 200 1
A 1C010 1 1 001 001 1
A 08000 1 1 002 002 1
A 18000 1 1 000 000 0
A 0FF70 1 0 000 000 0
A 0FF70 0 1 000 000 0
# D cpu_cyc rk_req my_req ack exp_owner(0 cpu 1 rk 2 my) exp_acks{my,rk,cpu}
D 0 1 1 0 0 0
D 0 1 1 1 1 2
D 0 0 1 0 1 0
D 0 0 1 1 2 4
D 1 0 0 0 2 0
D 1 1 0 1 0 1
D 1 1 0 0 0 0
D 0 1 0 0 0 0
D 0 1 0 1 1 2
D 0 0 0 0 1 0
D 0 0 0 0 0 0
# S sd_req{my,dx,dw,rk} sd_link exp_gnt exp_mosi exp_cs unused
S 0 39 0 0 1 0
S A 39 0 0 1 0
S A 39 2 1 0 0
S 8 39 2 1 0 0
S 8 39 0 0 1 0
S 8 39 8 0 0 0
S 0 39 8 0 0 0
S 0 39 0 0 1 0
# C speed txd{u1,u2,term,irps} lines_sel0 lines_sel1{u1rx,u2rx,termrx,irpstx} term_div ext_div
C 0 8 2 1 2FF 17
C 1 4 1 2 17F 17
C 2 2 8 4 BF 17
C 3 1 4 8 5F 17
C 4 A A 5 2F 17
C 5 5 5 A 17 17
C 6 C 3 3 F 17
C 7 3 C C 7 17

// File: tb.f
src/bus_pkg.sv
src/board_pkg.sv
src/bus_master_switch.sv
src/io_page_decoder.sv
src/sdcard_arbiter.sv
src/console_router.sv
src/board_fabric.sv
verification/tb_board_fabric.sv

// File: run_sim.sh
#!/bin/sh
# build and run the board fabric testbench with Verilator, from the project root

LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps -f tb.f \
	--top-module tb_board_fabric -o tb_board_fabric
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_board_fabric > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
fi

if grep -qx "No errors" "$LOG"; then
	exit 0
fi
echo "simulation failed, see $LOG"
exit 1
